// ==== logic/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus widths
`define AXI_DATA_W 64
`define AXI_ADDR_W 32
`define AXI_ID_W 4
`define AXI_LEN_W 8
`define AXI_STRB_W (`AXI_DATA_W / 8)

// bank array shape, beats interleave on word-address bits 4:3
`define NUM_BANKS 4
`define BANK_SEL_W 2
`define BANK_DEPTH 64
`define BANK_ROW_W 6

// start of the 2 KiB memory window
`define MEM_BASE 32'h8000_0000

// response queue depth, also the initial credit count
`define RESP_CREDITS 4

`endif

// ==== logic/axi_pkg.sv ====
package axi_pkg;

  // burst type encoding as on the bus
  // WRAP is walked like INCR
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_e;

  // only the two codes this target can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // front-end sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_READ,
    SEQ_WRITE
  } seq_state_e;

endpackage

// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // operation carried with a bank request
  typedef enum logic {
    BANK_READ,
    BANK_WRITE
  } bank_op_e;

  // kind of queued response
  // R per read beat, B once per write burst
  typedef enum logic {
    RESP_R,
    RESP_B
  } resp_kind_e;

endpackage

// ==== logic/axi_beat_sequencer.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module axi_beat_sequencer
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  logic [`AXI_ADDR_W-1:0]  ar_addr_i,
  input  logic [`AXI_ID_W-1:0]    ar_id_i,
  input  logic [`AXI_LEN_W-1:0]   ar_len_i,
  input  axi_burst_e              ar_burst_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  logic [`AXI_ADDR_W-1:0]  aw_addr_i,
  input  logic [`AXI_ID_W-1:0]    aw_id_i,
  input  logic [`AXI_LEN_W-1:0]   aw_len_i,
  input  axi_burst_e              aw_burst_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  logic [`AXI_DATA_W-1:0]  w_data_i,
  input  logic [`AXI_STRB_W-1:0]  w_strb_i,
  input  logic                    w_last_i,
  input  logic                    credit_return_i,
  output logic [`NUM_BANKS-1:0]   bank_req_o,
  output bank_op_e                bank_op_o,
  output logic [`BANK_ROW_W-1:0]  bank_row_o,
  output logic [`AXI_DATA_W-1:0]  bank_wdata_o,
  output logic [`AXI_STRB_W-1:0]  bank_wstrb_o,
  output logic                    tag_valid_o,
  output resp_kind_e              tag_kind_o,
  output logic [`AXI_ID_W-1:0]    tag_id_o,
  output logic                    tag_last_o,
  output logic                    tag_err_o,
  output logic [`BANK_SEL_W-1:0]  tag_bank_o
);

  localparam int CREDIT_W = $clog2(`RESP_CREDITS + 1);
  localparam int BEAT_SHIFT = $clog2(`AXI_STRB_W);
  localparam logic [`AXI_ADDR_W-1:0] WIN_BYTES =
    `AXI_ADDR_W'(`NUM_BANKS * `BANK_DEPTH * `AXI_STRB_W);
  localparam logic [`AXI_ADDR_W-1:0] BEAT_BYTES = `AXI_ADDR_W'(`AXI_STRB_W);

  seq_state_e              state;
  logic [CREDIT_W-1:0]     credits;
  logic [`AXI_ADDR_W-1:0]  cur_addr;
  logic [`AXI_ID_W-1:0]    hdr_id;
  logic [`AXI_LEN_W-1:0]   hdr_len;
  axi_burst_e              hdr_burst;
  logic [`AXI_LEN_W-1:0]   beat_cnt;
  logic                    wr_err;
  logic [`AXI_ADDR_W-1:0]  win_off;
  logic                    in_win;
  logic [`BANK_SEL_W-1:0]  bank_sel;
  logic                    last_beat;
  logic                    ar_hs;
  logic                    aw_hs;
  logic                    rd_fire;
  logic                    w_fire;
  logic                    beat_fire;

  // only idle takes a new header, read wins a tie
  assign ar_ready_o = (state == SEQ_IDLE);
  assign aw_ready_o = (state == SEQ_IDLE) && !ar_valid_i;
  assign ar_hs = ar_valid_i && ar_ready_o;
  assign aw_hs = aw_valid_i && aw_ready_o;

  // address decode, below-base wraps to a huge offset and fails the check
  assign win_off = cur_addr - `MEM_BASE;
  assign in_win = (win_off < WIN_BYTES);
  assign bank_sel = win_off[BEAT_SHIFT +: `BANK_SEL_W];
  assign bank_row_o = win_off[BEAT_SHIFT + `BANK_SEL_W +: `BANK_ROW_W];
  assign last_beat = (beat_cnt == hdr_len);

  // read beats need a credit each
  assign rd_fire = (state == SEQ_READ) && (credits != '0);
  // final write beat needs a credit for its B entry
  assign w_ready_o = (state == SEQ_WRITE) && (!last_beat || (credits != '0));
  assign w_fire = w_valid_i && w_ready_o;
  assign beat_fire = rd_fire || w_fire;

  // one-hot request, nothing for beats outside the window
  always_comb begin
    bank_req_o = '0;
    if (beat_fire && in_win) begin
      bank_req_o[bank_sel] = 1'b1;
    end
  end

  assign bank_op_o = (state == SEQ_WRITE) ? BANK_WRITE : BANK_READ;
  assign bank_wdata_o = w_data_i;
  assign bank_wstrb_o = w_strb_i;

  // tag goes out with every read beat and the last write beat
  assign tag_valid_o = rd_fire || (w_fire && last_beat);
  assign tag_kind_o = (state == SEQ_WRITE) ? RESP_B : RESP_R;
  assign tag_id_o = hdr_id;
  assign tag_last_o = last_beat;
  assign tag_err_o = (state == SEQ_WRITE) ? (wr_err || !in_win) : !in_win;
  assign tag_bank_o = bank_sel;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= SEQ_IDLE;
      credits <= CREDIT_W'(`RESP_CREDITS);
      beat_cnt <= '0;
      wr_err <= 1'b0;
    end else begin
      // spend on tag, refund on collector pop
      credits <= credits - CREDIT_W'(tag_valid_o) + CREDIT_W'(credit_return_i);
      case (state)
        SEQ_IDLE: begin
          beat_cnt <= '0;
          wr_err <= 1'b0;
          if (ar_hs) begin
            state <= SEQ_READ;
          end else if (aw_hs) begin
            state <= SEQ_WRITE;
          end
        end
        SEQ_READ: begin
          if (rd_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= SEQ_IDLE;
            end
          end
        end
        SEQ_WRITE: begin
          if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            // sticky across the burst
            wr_err <= wr_err || !in_win;
            if (last_beat) begin
              state <= SEQ_IDLE;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // burst header and running address
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      cur_addr <= ar_addr_i;
      hdr_id <= ar_id_i;
      hdr_len <= ar_len_i;
      hdr_burst <= ar_burst_i;
    end else if (aw_hs) begin
      cur_addr <= aw_addr_i;
      hdr_id <= aw_id_i;
      hdr_len <= aw_len_i;
      hdr_burst <= aw_burst_i;
    end else if (beat_fire && (hdr_burst != FIXED)) begin
      cur_addr <= cur_addr + BEAT_BYTES;
    end
  end

  // master's last flag must agree with the header length
  a_w_last_match: assert property (@(posedge clock) disable iff (!reset_n)
    w_fire |-> (w_last_i == last_beat));

  // returns never outrun spends
  a_credit_bound: assert property (@(posedge clock) disable iff (!reset_n)
    credits <= CREDIT_W'(`RESP_CREDITS));

endmodule

// ==== logic/mem_bank.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_bank
  import mem_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    req_i,
  input  bank_op_e                op_i,
  input  logic [`BANK_ROW_W-1:0]  row_i,
  input  logic [`AXI_DATA_W-1:0]  wdata_i,
  input  logic [`AXI_STRB_W-1:0]  wstrb_i,
  output logic [`AXI_DATA_W-1:0]  rdata_o
);

  // word storage, no reset on contents
  logic [`AXI_DATA_W-1:0] mem [`BANK_DEPTH];

  logic wr_en;
  logic rd_en;

  assign wr_en = req_i && (op_i == BANK_WRITE);
  assign rd_en = req_i && (op_i == BANK_READ);

  // byte lanes written at the request edge
  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // registered read port, data one cycle after request
  // holds last word when idle
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      rdata_o <= '0;
    end else if (rd_en) begin
      rdata_o <= mem[row_i];
    end
  end

  // write with no lanes enabled is a master bug
  a_wstrb_nonzero: assert property (@(posedge clock) disable iff (!reset_n)
    wr_en |-> (wstrb_i != '0));

endmodule

// ==== logic/resp_collector.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module resp_collector
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    tag_valid_i,
  input  resp_kind_e              tag_kind_i,
  input  logic [`AXI_ID_W-1:0]    tag_id_i,
  input  logic                    tag_last_i,
  input  logic                    tag_err_i,
  input  logic [`BANK_SEL_W-1:0]  tag_bank_i,
  input  logic [`AXI_DATA_W-1:0]  bank_rdata_i [`NUM_BANKS],
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output logic [`AXI_DATA_W-1:0]  r_data_o,
  output axi_resp_e               r_resp_o,
  output logic [`AXI_ID_W-1:0]    r_id_o,
  output logic                    r_last_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output axi_resp_e               b_resp_o,
  output logic [`AXI_ID_W-1:0]    b_id_o,
  output logic                    credit_return_o
);

  localparam int PTR_W = $clog2(`RESP_CREDITS);
  localparam int CNT_W = $clog2(`RESP_CREDITS + 1);

  // tag delayed one cycle to meet bank read data
  logic                    d_valid;
  resp_kind_e              d_kind;
  logic [`AXI_ID_W-1:0]    d_id;
  logic                    d_last;
  logic                    d_err;
  logic [`BANK_SEL_W-1:0]  d_bank;
  logic [`AXI_DATA_W-1:0]  push_data;

  // in-order response queue
  resp_kind_e              q_kind [`RESP_CREDITS];
  logic [`AXI_ID_W-1:0]    q_id   [`RESP_CREDITS];
  logic                    q_last [`RESP_CREDITS];
  logic                    q_err  [`RESP_CREDITS];
  logic [`AXI_DATA_W-1:0]  q_data [`RESP_CREDITS];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        q_count;
  logic                    q_empty;
  logic                    push;
  logic                    pop;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= tag_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    d_kind <= tag_kind_i;
    d_id <= tag_id_i;
    d_last <= tag_last_i;
    d_err <= tag_err_i;
    d_bank <= tag_bank_i;
  end

  // errored beats return zero, no bank was read
  assign push_data = d_err ? '0 : bank_rdata_i[d_bank];
  assign push = d_valid;

  always_ff @(posedge clock) begin
    if (push) begin
      q_kind[wr_ptr] <= d_kind;
      q_id[wr_ptr] <= d_id;
      q_last[wr_ptr] <= d_last;
      q_err[wr_ptr] <= d_err;
      q_data[wr_ptr] <= push_data;
    end
  end

  // head drives whichever channel its kind names
  assign q_empty = (q_count == '0);
  assign r_valid_o = !q_empty && (q_kind[rd_ptr] == RESP_R);
  assign b_valid_o = !q_empty && (q_kind[rd_ptr] == RESP_B);
  assign r_data_o = q_data[rd_ptr];
  assign r_resp_o = q_err[rd_ptr] ? SLVERR : OKAY;
  assign r_id_o = q_id[rd_ptr];
  assign r_last_o = q_last[rd_ptr];
  assign b_resp_o = q_err[rd_ptr] ? SLVERR : OKAY;
  assign b_id_o = q_id[rd_ptr];

  assign pop = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);
  // one credit back per handshake
  assign credit_return_o = pop;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      q_count <= q_count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // credit loop with the sequencer keeps a slot for every tag
  a_no_overflow: assert property (@(posedge clock) disable iff (!reset_n)
    push |-> (q_count < CNT_W'(`RESP_CREDITS)));

endmodule

// ==== logic/axi_mem_top.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module axi_mem_top
  import axi_pkg::*;
  import mem_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset_n,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  input  logic [`AXI_ADDR_W-1:0]  ar_addr_i,
  input  logic [`AXI_ID_W-1:0]    ar_id_i,
  input  logic [`AXI_LEN_W-1:0]   ar_len_i,
  input  axi_burst_e              ar_burst_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  logic [`AXI_ADDR_W-1:0]  aw_addr_i,
  input  logic [`AXI_ID_W-1:0]    aw_id_i,
  input  logic [`AXI_LEN_W-1:0]   aw_len_i,
  input  axi_burst_e              aw_burst_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  logic [`AXI_DATA_W-1:0]  w_data_i,
  input  logic [`AXI_STRB_W-1:0]  w_strb_i,
  input  logic                    w_last_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output logic [`AXI_DATA_W-1:0]  r_data_o,
  output axi_resp_e               r_resp_o,
  output logic [`AXI_ID_W-1:0]    r_id_o,
  output logic                    r_last_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  output axi_resp_e               b_resp_o,
  output logic [`AXI_ID_W-1:0]    b_id_o
);

  // shared bank request bus
  logic [`NUM_BANKS-1:0]   bank_req;
  bank_op_e                bank_op;
  logic [`BANK_ROW_W-1:0]  bank_row;
  logic [`AXI_DATA_W-1:0]  bank_wdata;
  logic [`AXI_STRB_W-1:0]  bank_wstrb;
  logic [`AXI_DATA_W-1:0]  bank_rdata [`NUM_BANKS];

  // tag path and credit loop
  logic                    tag_valid;
  resp_kind_e              tag_kind;
  logic [`AXI_ID_W-1:0]    tag_id;
  logic                    tag_last;
  logic                    tag_err;
  logic [`BANK_SEL_W-1:0]  tag_bank;
  logic                    credit_return;

  axi_beat_sequencer axi_beat_sequencer_i (
    .clock(clock), .reset_n(reset_n),
    .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o), .ar_addr_i(ar_addr_i),
    .ar_id_i(ar_id_i), .ar_len_i(ar_len_i), .ar_burst_i(ar_burst_i),
    .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o), .aw_addr_i(aw_addr_i),
    .aw_id_i(aw_id_i), .aw_len_i(aw_len_i), .aw_burst_i(aw_burst_i),
    .w_valid_i(w_valid_i), .w_ready_o(w_ready_o), .w_data_i(w_data_i),
    .w_strb_i(w_strb_i), .w_last_i(w_last_i),
    .credit_return_i(credit_return),
    .bank_req_o(bank_req), .bank_op_o(bank_op), .bank_row_o(bank_row),
    .bank_wdata_o(bank_wdata), .bank_wstrb_o(bank_wstrb),
    .tag_valid_o(tag_valid), .tag_kind_o(tag_kind), .tag_id_o(tag_id),
    .tag_last_o(tag_last), .tag_err_o(tag_err), .tag_bank_o(tag_bank)
  );

  // one bank per interleave slot
  for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
    mem_bank mem_bank_i (
      .clock(clock), .reset_n(reset_n),
      .req_i(bank_req[g]), .op_i(bank_op), .row_i(bank_row),
      .wdata_i(bank_wdata), .wstrb_i(bank_wstrb), .rdata_o(bank_rdata[g])
    );
  end

  resp_collector resp_collector_i (
    .clock(clock), .reset_n(reset_n),
    .tag_valid_i(tag_valid), .tag_kind_i(tag_kind), .tag_id_i(tag_id),
    .tag_last_i(tag_last), .tag_err_i(tag_err), .tag_bank_i(tag_bank),
    .bank_rdata_i(bank_rdata),
    .r_valid_o(r_valid_o), .r_ready_i(r_ready_i), .r_data_o(r_data_o),
    .r_resp_o(r_resp_o), .r_id_o(r_id_o), .r_last_o(r_last_o),
    .b_valid_o(b_valid_o), .b_ready_i(b_ready_i), .b_resp_o(b_resp_o),
    .b_id_o(b_id_o), .credit_return_o(credit_return)
  );

endmodule

// ==== verif/axi_mem_tb.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module axi_mem_tb
  import axi_pkg::*;
();

  // whole run needs under 700 cycles and the 256-beat window read is the longest piece
  localparam int MAX_CYCLES = 4000;
  localparam logic [31:0] WIN_BYTES = 32'(`NUM_BANKS * `BANK_DEPTH * 8);

  logic                    clock;
  logic                    reset_n;
  logic                    ar_valid_i;
  logic                    ar_ready_o;
  logic [`AXI_ADDR_W-1:0]  ar_addr_i;
  logic [`AXI_ID_W-1:0]    ar_id_i;
  logic [`AXI_LEN_W-1:0]   ar_len_i;
  axi_burst_e              ar_burst_i;
  logic                    aw_valid_i;
  logic                    aw_ready_o;
  logic [`AXI_ADDR_W-1:0]  aw_addr_i;
  logic [`AXI_ID_W-1:0]    aw_id_i;
  logic [`AXI_LEN_W-1:0]   aw_len_i;
  axi_burst_e              aw_burst_i;
  logic                    w_valid_i;
  logic                    w_ready_o;
  logic [`AXI_DATA_W-1:0]  w_data_i;
  logic [`AXI_STRB_W-1:0]  w_strb_i;
  logic                    w_last_i;
  logic                    r_valid_o;
  logic                    r_ready_i;
  logic [`AXI_DATA_W-1:0]  r_data_o;
  axi_resp_e               r_resp_o;
  logic [`AXI_ID_W-1:0]    r_id_o;
  logic                    r_last_o;
  logic                    b_valid_o;
  logic                    b_ready_i;
  axi_resp_e               b_resp_o;
  logic [`AXI_ID_W-1:0]    b_id_o;

  // reference memory split by bank and row like the interleave
  logic [63:0]             ref_mem [`NUM_BANKS][`BANK_DEPTH];
  logic                    ref_known [`NUM_BANKS][`BANK_DEPTH];
  // beats to send and beats received
  logic [63:0]             wbuf_data [256];
  logic [7:0]              wbuf_strb [256];
  logic [63:0]             rbuf_data [256];
  axi_resp_e               rbuf_resp [256];
  logic [`AXI_ID_W-1:0]    rbuf_id [256];
  logic                    rbuf_last [256];
  int                      errors;
  int                      tests_run;
  int                      tests_failed;
  int                      cycles;

  axi_mem_top axi_mem_top_i (
    .clock(clock), .reset_n(reset_n),
    .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o), .ar_addr_i(ar_addr_i),
    .ar_id_i(ar_id_i), .ar_len_i(ar_len_i), .ar_burst_i(ar_burst_i),
    .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o), .aw_addr_i(aw_addr_i),
    .aw_id_i(aw_id_i), .aw_len_i(aw_len_i), .aw_burst_i(aw_burst_i),
    .w_valid_i(w_valid_i), .w_ready_o(w_ready_o), .w_data_i(w_data_i),
    .w_strb_i(w_strb_i), .w_last_i(w_last_i),
    .r_valid_o(r_valid_o), .r_ready_i(r_ready_i), .r_data_o(r_data_o),
    .r_resp_o(r_resp_o), .r_id_o(r_id_o), .r_last_o(r_last_o),
    .b_valid_o(b_valid_o), .b_ready_i(b_ready_i), .b_resp_o(b_resp_o),
    .b_id_o(b_id_o)
  );

  always #20 clock = ~clock;

  // run limit
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d clock cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // window spans 2 KiB upward from the base
  function automatic logic in_window(input logic [31:0] addr);
    return (addr >= `MEM_BASE) && (addr < `MEM_BASE + WIN_BYTES);
  endfunction

  // INCR and WRAP step one word while FIXED stays
  function automatic logic [31:0] next_addr(input logic [31:0] addr, input axi_burst_e burst);
    return (burst == FIXED) ? addr : addr + 32'd8;
  endfunction

  // word offset bits 4:3 pick the bank and bits 10:5 the row
  function automatic void ref_write(input logic [31:0] addr, input logic [63:0] data,
                                    input logic [7:0] strb);
    logic [31:0] off;
    off = addr - `MEM_BASE;
    if (in_window(addr)) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          ref_mem[off[4:3]][off[10:5]][b*8 +: 8] = data[b*8 +: 8];
        end
      end
      ref_known[off[4:3]][off[10:5]] = 1'b1;
    end
  endfunction

  // out-of-window beats read as zero
  function automatic logic [63:0] ref_read(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `MEM_BASE;
    return in_window(addr) ? ref_mem[off[4:3]][off[10:5]] : 64'd0;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d mismatches", name, errors - errs_before);
    end
  endtask

  task automatic fill_random(input int beats);
    for (int i = 0; i < beats; i++) begin
      wbuf_data[i] = {$urandom, $urandom};
      wbuf_strb[i] = 8'hff;
    end
  endtask

  task automatic do_write_burst(input logic [31:0] addr, input logic [`AXI_ID_W-1:0] id,
                                input int beats, input axi_burst_e burst,
                                output axi_resp_e resp, output logic [`AXI_ID_W-1:0] bid);
    logic [31:0] a;
    int i;
    a = addr;
    i = 0;
    @(negedge clock);
    aw_valid_i = 1'b1;
    aw_addr_i = addr;
    aw_id_i = id;
    aw_len_i = 8'(beats - 1);
    aw_burst_i = burst;
    // ready is sampled after inputs settle and the handshake lands on the next rising edge
    #1;
    while (!aw_ready_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    aw_valid_i = 1'b0;
    b_ready_i = 1'b1;
    while (i < beats) begin
      w_valid_i = 1'b1;
      w_data_i = wbuf_data[i];
      w_strb_i = wbuf_strb[i];
      w_last_i = (i == beats - 1);
      #1;
      if (w_ready_o) begin
        ref_write(a, wbuf_data[i], wbuf_strb[i]);
        a = next_addr(a, burst);
        i++;
      end
      @(negedge clock);
    end
    w_valid_i = 1'b0;
    w_last_i = 1'b0;
    #1;
    while (!b_valid_o) begin
      @(negedge clock);
      #1;
    end
    resp = b_resp_o;
    bid = b_id_o;
    @(negedge clock);
    b_ready_i = 1'b0;
  endtask

  // stall drops r_ready on about half the cycles
  task automatic do_read_burst(input logic [31:0] addr, input logic [`AXI_ID_W-1:0] id,
                               input int beats, input axi_burst_e burst, input logic stall);
    int n;
    n = 0;
    @(negedge clock);
    ar_valid_i = 1'b1;
    ar_addr_i = addr;
    ar_id_i = id;
    ar_len_i = 8'(beats - 1);
    ar_burst_i = burst;
    #1;
    while (!ar_ready_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    ar_valid_i = 1'b0;
    while (n < beats) begin
      r_ready_i = stall ? 1'($urandom) : 1'b1;
      #1;
      if (r_valid_o && r_ready_i) begin
        rbuf_data[n] = r_data_o;
        rbuf_resp[n] = r_resp_o;
        rbuf_id[n] = r_id_o;
        rbuf_last[n] = r_last_o;
        n++;
      end
      @(negedge clock);
    end
    r_ready_i = 1'b0;
  endtask

  task automatic check_b(input axi_resp_e resp, input logic [`AXI_ID_W-1:0] bid,
                         input axi_resp_e exp_resp, input logic [`AXI_ID_W-1:0] exp_id);
    if (resp !== exp_resp) begin
      report_mismatch("b_resp_o", 64'(exp_resp), 64'(resp));
    end
    if (bid !== exp_id) begin
      report_mismatch("b_id_o", 64'(exp_id), 64'(bid));
    end
  endtask

  // words never written are skipped for data only
  task automatic check_read(input logic [31:0] addr, input axi_burst_e burst,
                            input int beats, input logic [`AXI_ID_W-1:0] id);
    logic [31:0] a;
    logic [31:0] off;
    axi_resp_e exp_resp;
    a = addr;
    for (int i = 0; i < beats; i++) begin
      off = a - `MEM_BASE;
      exp_resp = in_window(a) ? OKAY : SLVERR;
      if (!in_window(a) || ref_known[off[4:3]][off[10:5]]) begin
        if (rbuf_data[i] !== ref_read(a)) begin
          report_mismatch($sformatf("r_data_o beat %0d", i), ref_read(a), rbuf_data[i]);
        end
      end
      if (rbuf_resp[i] !== exp_resp) begin
        report_mismatch($sformatf("r_resp_o beat %0d", i), 64'(exp_resp), 64'(rbuf_resp[i]));
      end
      if (rbuf_id[i] !== id) begin
        report_mismatch($sformatf("r_id_o beat %0d", i), 64'(id), 64'(rbuf_id[i]));
      end
      if (rbuf_last[i] !== (i == beats - 1)) begin
        report_mismatch($sformatf("r_last_o beat %0d", i), 64'(i == beats - 1),
                        64'(rbuf_last[i]));
      end
      a = next_addr(a, burst);
    end
  endtask

  task automatic reset_outputs();
    int errs;
    errs = errors;
    if (r_valid_o !== 1'b0) begin
      report_mismatch("r_valid_o", 64'd0, 64'(r_valid_o));
    end
    if (b_valid_o !== 1'b0) begin
      report_mismatch("b_valid_o", 64'd0, 64'(b_valid_o));
    end
    if (w_ready_o !== 1'b0) begin
      report_mismatch("w_ready_o", 64'd0, 64'(w_ready_o));
    end
    if (ar_ready_o !== 1'b1) begin
      report_mismatch("ar_ready_o", 64'd1, 64'(ar_ready_o));
    end
    if (aw_ready_o !== 1'b1) begin
      report_mismatch("aw_ready_o", 64'd1, 64'(aw_ready_o));
    end
    finish_test("reset", errs);
  endtask

  // words 4..7 land in banks 0..3
  task automatic incr_round_trip();
    int errs;
    axi_resp_e resp;
    logic [`AXI_ID_W-1:0] bid;
    errs = errors;
    fill_random(4);
    do_write_burst(`MEM_BASE + 32'h20, 4'h3, 4, INCR, resp, bid);
    check_b(resp, bid, OKAY, 4'h3);
    do_read_burst(`MEM_BASE + 32'h20, 4'h5, 4, INCR, 1'b0);
    check_read(`MEM_BASE + 32'h20, INCR, 4, 4'h5);
    finish_test("incr_round_trip", errs);
  endtask

  task automatic byte_strobe_merge();
    int errs;
    axi_resp_e resp;
    logic [`AXI_ID_W-1:0] bid;
    errs = errors;
    fill_random(1);
    do_write_burst(`MEM_BASE + 32'h100, 4'h1, 1, INCR, resp, bid);
    check_b(resp, bid, OKAY, 4'h1);
    // even byte lanes only
    wbuf_data[0] = {$urandom, $urandom};
    wbuf_strb[0] = 8'h55;
    do_write_burst(`MEM_BASE + 32'h100, 4'h2, 1, INCR, resp, bid);
    check_b(resp, bid, OKAY, 4'h2);
    do_read_burst(`MEM_BASE + 32'h100, 4'h6, 1, INCR, 1'b0);
    check_read(`MEM_BASE + 32'h100, INCR, 1, 4'h6);
    finish_test("byte_strobes", errs);
  endtask

  task automatic fixed_burst_overwrite();
    int errs;
    axi_resp_e resp;
    logic [`AXI_ID_W-1:0] bid;
    errs = errors;
    // neighbors first and then three beats onto the middle word
    fill_random(3);
    do_write_burst(`MEM_BASE + 32'h180, 4'h7, 3, INCR, resp, bid);
    check_b(resp, bid, OKAY, 4'h7);
    fill_random(3);
    do_write_burst(`MEM_BASE + 32'h188, 4'h8, 3, FIXED, resp, bid);
    check_b(resp, bid, OKAY, 4'h8);
    do_read_burst(`MEM_BASE + 32'h180, 4'h9, 3, INCR, 1'b0);
    check_read(`MEM_BASE + 32'h180, INCR, 3, 4'h9);
    if (rbuf_data[1] !== wbuf_data[2]) begin
      report_mismatch("r_data_o fixed word", wbuf_data[2], rbuf_data[1]);
    end
    do_read_burst(`MEM_BASE + 32'h188, 4'ha, 3, FIXED, 1'b0);
    check_read(`MEM_BASE + 32'h188, FIXED, 3, 4'ha);
    finish_test("fixed_bursts", errs);
  endtask

  // 16 beats against 4 credits with a stalling master
  task automatic stalled_read();
    int errs;
    axi_resp_e resp;
    logic [`AXI_ID_W-1:0] bid;
    errs = errors;
    fill_random(16);
    do_write_burst(`MEM_BASE + 32'h200, 4'hb, 16, INCR, resp, bid);
    check_b(resp, bid, OKAY, 4'hb);
    do_read_burst(`MEM_BASE + 32'h200, 4'hc, 16, INCR, 1'b1);
    check_read(`MEM_BASE + 32'h200, INCR, 16, 4'hc);
    fill_random(1);
    do_write_burst(`MEM_BASE + 32'h300, 4'hd, 1, INCR, resp, bid);
    check_b(resp, bid, OKAY, 4'hd);
    finish_test("back_pressure", errs);
  endtask

  task automatic window_bounds();
    int errs;
    axi_resp_e resp;
    logic [`AXI_ID_W-1:0] bid;
    errs = errors;
    // first beat below the window and the second at its base
    fill_random(2);
    do_write_burst(`MEM_BASE - 32'h8, 4'h1, 2, INCR, resp, bid);
    check_b(resp, bid, SLVERR, 4'h1);
    do_read_burst(`MEM_BASE + WIN_BYTES, 4'h2, 2, INCR, 1'b0);
    check_read(`MEM_BASE + WIN_BYTES, INCR, 2, 4'h2);
    // sweep of every word in the window
    do_read_burst(`MEM_BASE, 4'h4, 256, INCR, 1'b0);
    check_read(`MEM_BASE, INCR, 256, 4'h4);
    finish_test("out_of_window", errs);
  endtask

  initial begin
    void'($urandom(71));
    clock = 1'b0;
    reset_n = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_id_i = '0;
    ar_len_i = '0;
    ar_burst_i = INCR;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_id_i = '0;
    aw_len_i = '0;
    aw_burst_i = INCR;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    w_last_i = 1'b0;
    r_ready_i = 1'b0;
    b_ready_i = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycles = 0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int r = 0; r < `BANK_DEPTH; r++) begin
        ref_mem[b][r] = '0;
        ref_known[b][r] = 1'b0;
      end
    end
    repeat (8) @(negedge clock);
    reset_n = 1'b1;
    #1;
    reset_outputs();
    incr_round_trip();
    byte_strobe_merge();
    fixed_burst_overwrite();
    stalled_read();
    window_bounds();
    $display("summary: %0d tests run, %0d failed, %0d mismatches",
             tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/axi_beat_sequencer.sv
logic/mem_bank.sv
logic/resp_collector.sv
logic/axi_mem_top.sv
verif/axi_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the AXI memory target
TB_TOP := axi_mem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TB_TOP)

# the run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
